//--- dcachePkg.sv
package dcachePkg;

  // geometry
  localparam int NumWays      = 2;
  localparam int NumSets      = 64;
  localparam int BeatsPerLine = 4;

  // address split: tag | index | offset
  localparam int OffsetBits = 5;
  localparam int IndexBits  = 6;
  localparam int TagBits    = 21;

  typedef logic [31:0]                 addrT;
  typedef logic [63:0]                 wordT;
  typedef logic [BeatsPerLine*64-1:0]  lineT;
  typedef logic [7:0]                  maskT;
  typedef logic [TagBits-1:0]          tagT;
  typedef logic [IndexBits-1:0]        indexT;
  typedef logic [1:0]                  beatT;
  typedef logic                        wayT;

  // one load or store from the pipeline
  typedef struct packed {
    logic isStore;
    addrT addr;
    wordT wrData;
    maskT wrMask;
  } cacheReqT;

  // dirty line going back to memory
  typedef struct packed {
    addrT addr;
    lineT data;
  } wbReqT;

  typedef enum logic [2:0] {
    stIdle,
    stCompare,
    stWriteBack,
    stMissReq,
    stRefill,
    stReplace
  } cacheStateT;

endpackage

//--- dcacheCtrl.sv
module dcacheCtrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 reqValid_i,
  input  dcachePkg::cacheReqT  req_i,
  input  logic                 hit_i,
  input  dcachePkg::wayT       hitWay_i,
  input  logic                 victimDirty_i,
  input  dcachePkg::tagT       victimTag_i,
  input  dcachePkg::lineT      victimLine_i,
  input  logic                 rdReqReady_i,
  input  logic                 rdBeatValid_i,
  input  logic                 rdLast_i,
  input  logic                 wbReady_i,
  output logic                 reqReady_o,
  output dcachePkg::cacheReqT  curReq_o,
  output logic                 lookupEn_o,
  output logic                 storeEn_o,
  output dcachePkg::wayT       storeWay_o,
  output logic                 replaceEn_o,
  output dcachePkg::wayT       victimWay_o,
  output logic                 refillEn_o,
  output logic                 dataOk_o,
  output logic                 rdReqValid_o,
  output dcachePkg::addrT      rdReqAddr_o,
  output logic                 wbValid_o,
  output dcachePkg::wbReqT     wb_o
);
  import dcachePkg::*;

  cacheStateT curState;
  cacheStateT nextState;
  cacheReqT   reqQ;
  wayT        victimBit;
  wayT        victimWayQ;
  logic       compareMiss;

  assign compareMiss = (curState == stCompare) && !hit_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curState <= stIdle;
    end else begin
      curState <= nextState;
    end
  end

  always_comb begin
    nextState = curState;
    unique case (curState)
      stIdle: begin
        if (reqValid_i) begin
          nextState = stCompare;
        end
      end
      stCompare: begin
        if (hit_i) begin
          nextState = stIdle;
        end else if (victimDirty_i) begin
          nextState = stWriteBack;
        end else begin
          nextState = stMissReq;
        end
      end
      stWriteBack: begin
        if (wbReady_i) begin
          nextState = stMissReq;
        end
      end
      stMissReq: begin
        if (rdReqReady_i) begin
          nextState = stRefill;
        end
      end
      stRefill: begin
        // fourth beat closes the refill
        if (rdBeatValid_i && rdLast_i) begin
          nextState = stReplace;
        end
      end
      stReplace: begin
        // retry the lookup, it hits now
        nextState = stCompare;
      end
      default: begin
        nextState = stIdle;
      end
    endcase
  end

  // hold the accepted request for the whole transaction
  always_ff @(posedge clk) begin
    if (reqReady_o && reqValid_i) begin
      reqQ <= req_i;
    end
  end

  // toggle picks the victim, flips on every miss
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimBit  <= 1'b0;
      victimWayQ <= 1'b0;
    end else if (compareMiss) begin
      victimWayQ <= victimBit;
      victimBit  <= ~victimBit;
    end
  end

  assign reqReady_o = (curState == stIdle);

  // in idle the incoming request drives the array read
  assign curReq_o   = reqReady_o ? req_i : reqQ;
  assign lookupEn_o = reqReady_o && reqValid_i;

  assign storeEn_o   = (curState == stCompare) && hit_i && reqQ.isStore;
  assign storeWay_o  = hitWay_i;
  assign dataOk_o    = (curState == stCompare) && hit_i;
  assign replaceEn_o = (curState == stReplace);
  assign refillEn_o  = (curState == stRefill);

  // compare still sees the toggle before it flips
  assign victimWay_o = (curState == stCompare) ? victimBit : victimWayQ;

  assign rdReqValid_o = (curState == stMissReq);
  assign rdReqAddr_o  = {reqQ.addr[$bits(addrT)-1:OffsetBits], {OffsetBits{1'b0}}};

  // victim address rebuilt from its stored tag
  assign wbValid_o    = (curState == stWriteBack);
  assign wb_o.addr    = {victimTag_i, reqQ.addr[OffsetBits +: IndexBits], {OffsetBits{1'b0}}};
  assign wb_o.data    = victimLine_i;

endmodule

//--- tagStore.sv
module tagStore (
  input  logic             clk,
  input  logic             rst_n,
  input  dcachePkg::indexT index_i,
  input  dcachePkg::tagT   tag_i,
  input  logic             markDirty_i,
  input  dcachePkg::wayT   dirtyWay_i,
  input  logic             replaceEn_i,
  input  dcachePkg::wayT   victimWay_i,
  input  logic             replaceDirty_i,
  output logic             hit_o,
  output dcachePkg::wayT   hitWay_o,
  output logic             victimDirty_o,
  output dcachePkg::tagT   victimTag_o
);
  import dcachePkg::*;

  tagT                tagMem   [NumWays][NumSets];
  logic [NumSets-1:0] validMem [NumWays];
  logic [NumSets-1:0] dirtyMem [NumWays];
  logic [NumWays-1:0] wayHit;

  // tag array, cleared so a fresh victim has a known address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < NumWays; w++) begin
        for (int s = 0; s < NumSets; s++) begin
          tagMem[w][s] <= '0;
        end
      end
    end else if (replaceEn_i) begin
      tagMem[victimWay_i][index_i] <= tag_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < NumWays; w++) begin
        validMem[w] <= '0;
      end
    end else if (replaceEn_i) begin
      validMem[victimWay_i][index_i] <= 1'b1;
    end
  end

  // dirty on store hit, or on refill of a store miss
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < NumWays; w++) begin
        dirtyMem[w] <= '0;
      end
    end else if (replaceEn_i) begin
      dirtyMem[victimWay_i][index_i] <= replaceDirty_i;
    end else if (markDirty_i) begin
      dirtyMem[dirtyWay_i][index_i] <= 1'b1;
    end
  end

  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      wayHit[w] = validMem[w][index_i] && (tagMem[w][index_i] == tag_i);
    end
  end

  assign hit_o    = |wayHit;
  // two ways, so way 1 hitting names the way
  assign hitWay_o = wayHit[1];

  assign victimDirty_o = validMem[victimWay_i][index_i] && dirtyMem[victimWay_i][index_i];
  assign victimTag_o   = tagMem[victimWay_i][index_i];

endmodule

//--- dataStore.sv
module dataStore (
  input  logic                 clk,
  input  logic                 readEn_i,
  input  dcachePkg::indexT     readIndex_i,
  input  dcachePkg::beatT      wordSel_i,
  input  dcachePkg::wayT       hitWay_i,
  input  logic                 storeEn_i,
  input  dcachePkg::cacheReqT  req_i,
  input  logic                 replaceEn_i,
  input  dcachePkg::wayT       replaceWay_i,
  input  dcachePkg::lineT      refillLine_i,
  output dcachePkg::wordT      rdData_o,
  output dcachePkg::lineT      victimLine_o
);
  import dcachePkg::*;

  lineT wayMem [NumWays][NumSets];
  lineT rdLine [NumWays];
  lineT storeLine;
  lineT replaceLine;

  // byte-masked merge of one word into a line
  function automatic lineT mergeWord(lineT line, beatT sel, wordT data, maskT mask);
    lineT merged;
    merged = line;
    for (int b = 0; b < $bits(maskT); b++) begin
      if (mask[b]) begin
        merged[sel*64 + b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return merged;
  endfunction

  // rdLine holds the current set, so it is the base for a store
  assign storeLine = mergeWord(rdLine[hitWay_i], wordSel_i, req_i.wrData, req_i.wrMask);

  assign replaceLine = req_i.isStore
                     ? mergeWord(refillLine_i, wordSel_i, req_i.wrData, req_i.wrMask)
                     : refillLine_i;

  always_ff @(posedge clk) begin
    if (replaceEn_i) begin
      wayMem[replaceWay_i][readIndex_i] <= replaceLine;
    end else if (storeEn_i) begin
      wayMem[hitWay_i][readIndex_i] <= storeLine;
    end
  end

  // registered read, refilled line goes straight into the read register
  always_ff @(posedge clk) begin
    for (int w = 0; w < NumWays; w++) begin
      if (replaceEn_i && (replaceWay_i == wayT'(w))) begin
        rdLine[w] <= replaceLine;
      end else if (readEn_i) begin
        rdLine[w] <= wayMem[w][readIndex_i];
      end
    end
  end

  assign rdData_o     = rdLine[hitWay_i][wordSel_i*64 +: 64];
  assign victimLine_o = rdLine[replaceWay_i];

endmodule

//--- refillBuffer.sv
module refillBuffer (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            refillEn_i,
  input  logic            beatValid_i,
  input  dcachePkg::wordT beat_i,
  output dcachePkg::lineT line_o
);
  import dcachePkg::*;

  beatT beatCnt;
  lineT lineBuf;

  // counter wraps after the fourth beat, ready for the next miss
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (refillEn_i && beatValid_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // lowest word arrives first
  always_ff @(posedge clk) begin
    if (refillEn_i && beatValid_i) begin
      lineBuf[beatCnt*64 +: 64] <= beat_i;
    end
  end

  assign line_o = lineBuf;

endmodule

//--- dcacheTop.sv
module dcacheTop (
  input  logic                 clk,
  input  logic                 rst_n,
  // pipeline side
  input  logic                 reqValid_i,
  input  dcachePkg::cacheReqT  req_i,
  output logic                 reqReady_o,
  output logic                 dataOk_o,
  output dcachePkg::wordT      rdData_o,
  // memory read
  output logic                 rdReqValid_o,
  output dcachePkg::addrT      rdReqAddr_o,
  input  logic                 rdReqReady_i,
  input  logic                 rdBeatValid_i,
  input  dcachePkg::wordT      rdBeat_i,
  input  logic                 rdLast_i,
  // memory write-back
  output logic                 wbValid_o,
  output dcachePkg::wbReqT     wb_o,
  input  logic                 wbReady_i
);
  import dcachePkg::*;

  cacheReqT curReq;
  logic     hit;
  wayT      hitWay;
  logic     victimDirty;
  tagT      victimTag;
  lineT     victimLine;
  logic     lookupEn;
  logic     storeEn;
  wayT      storeWay;
  logic     replaceEn;
  wayT      victimWay;
  logic     refillEn;
  lineT     refillLine;

  dcacheCtrl dcacheCtrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .req_i         (req_i),
    .hit_i         (hit),
    .hitWay_i      (hitWay),
    .victimDirty_i (victimDirty),
    .victimTag_i   (victimTag),
    .victimLine_i  (victimLine),
    .rdReqReady_i  (rdReqReady_i),
    .rdBeatValid_i (rdBeatValid_i),
    .rdLast_i      (rdLast_i),
    .wbReady_i     (wbReady_i),
    .reqReady_o    (reqReady_o),
    .curReq_o      (curReq),
    .lookupEn_o    (lookupEn),
    .storeEn_o     (storeEn),
    .storeWay_o    (storeWay),
    .replaceEn_o   (replaceEn),
    .victimWay_o   (victimWay),
    .refillEn_o    (refillEn),
    .dataOk_o      (dataOk_o),
    .rdReqValid_o  (rdReqValid_o),
    .rdReqAddr_o   (rdReqAddr_o),
    .wbValid_o     (wbValid_o),
    .wb_o          (wb_o)
  );

  tagStore tagStore_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .index_i        (curReq.addr[OffsetBits +: IndexBits]),
    .tag_i          (curReq.addr[OffsetBits + IndexBits +: TagBits]),
    .markDirty_i    (storeEn),
    .dirtyWay_i     (storeWay),
    .replaceEn_i    (replaceEn),
    .victimWay_i    (victimWay),
    .replaceDirty_i (curReq.isStore),
    .hit_o          (hit),
    .hitWay_o       (hitWay),
    .victimDirty_o  (victimDirty),
    .victimTag_o    (victimTag)
  );

  dataStore dataStore_i (
    .clk          (clk),
    .readEn_i     (lookupEn),
    .readIndex_i  (curReq.addr[OffsetBits +: IndexBits]),
    .wordSel_i    (curReq.addr[OffsetBits-1 -: $bits(beatT)]),
    .hitWay_i     (hitWay),
    .storeEn_i    (storeEn),
    .req_i        (curReq),
    .replaceEn_i  (replaceEn),
    .replaceWay_i (victimWay),
    .refillLine_i (refillLine),
    .rdData_o     (rdData_o),
    .victimLine_o (victimLine)
  );

  refillBuffer refillBuffer_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .refillEn_i  (refillEn),
    .beatValid_i (rdBeatValid_i),
    .beat_i      (rdBeat_i),
    .line_o      (refillLine)
  );

endmodule

//--- dcache_assert.sv
module dcacheAssert (
  input logic              clk,
  input logic              rst_n,
  input logic              reqReady_i,
  input logic              dataOk_i,
  input logic              rdReqValid_i,
  input dcachePkg::addrT   rdReqAddr_i,
  input logic              rdReqReady_i,
  input logic              wbValid_i,
  input dcachePkg::wbReqT  wb_i,
  input logic              wbReady_i
);

  // write-back stays up and unchanged until memory takes it
  wbHold: assert property (@(posedge clk) disable iff (!rst_n)
    wbValid_i && !wbReady_i |=> wbValid_i && $stable(wb_i))
    else $error("write-back request dropped or changed before wbReady_i");

  rdReqHold: assert property (@(posedge clk) disable iff (!rst_n)
    rdReqValid_i && !rdReqReady_i |=> rdReqValid_i && $stable(rdReqAddr_i))
    else $error("read request dropped or changed before rdReqReady_i");

  // idle comes back only through a completion pulse
  readyAfterDone: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(reqReady_i) |-> $past(dataOk_i))
    else $error("reqReady_o rose without a dataOk_o pulse before it");

endmodule

bind dcacheTop dcacheAssert dcacheAssert_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .reqReady_i   (reqReady_o),
  .dataOk_i     (dataOk_o),
  .rdReqValid_i (rdReqValid_o),
  .rdReqAddr_i  (rdReqAddr_o),
  .rdReqReady_i (rdReqReady_i),
  .wbValid_i    (wbValid_o),
  .wb_i         (wb_o),
  .wbReady_i    (wbReady_i)
);

//--- dcacheTb.sv
module dcacheTb;
  import dcachePkg::*;

  // sized for about 300 requests of up to 40 cycles each
  localparam int TimeoutCycles = 20000;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     reqValid_i;
  cacheReqT req_i;
  logic     reqReady_o;
  logic     dataOk_o;
  wordT     rdData_o;
  logic     rdReqValid_o;
  addrT     rdReqAddr_o;
  logic     rdReqReady_i = 1'b0;
  logic     rdBeatValid_i = 1'b0;
  wordT     rdBeat_i = '0;
  logic     rdLast_i = 1'b0;
  logic     wbValid_o;
  wbReqT    wb_o;
  logic     wbReady_i = 1'b0;

  wordT        memModel [addrT];
  wordT        shadow [addrT];
  logic [31:0] lfsrState;
  bit          bpOn;
  bit          rdActive;
  int          beatIdx;
  addrT        rdAddr;
  addrT        lastRdAddr;
  addrT        lastWbAddr;
  int          rdCount;
  int          wbCount;
  int          errCount;
  int          checkCount;
  int          cycleCount;

  dcacheTop dcacheTop_i (.*);

  always #50 clk = ~clk;

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = {lfsrState[30:0], lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
      r = {r[30:0], lfsrState[0]};
    end
    return r;
  endfunction

  function automatic addrT mkAddr(input int tag, input int idx, input int word);
    return {tagT'(tag), indexT'(idx), beatT'(word), 3'b000};
  endfunction

  function automatic addrT lineOf(input addrT a);
    return {a[31:OffsetBits], {OffsetBits{1'b0}}};
  endfunction

  // untouched memory holds its own word address twice
  function automatic wordT memRead(input addrT a);
    addrT w;
    w = {a[31:3], 3'b000};
    return memModel.exists(w) ? memModel[w] : {w, w};
  endfunction

  // what the pipeline should see for this word
  function automatic wordT expectRead(input addrT a);
    addrT w;
    w = {a[31:3], 3'b000};
    return shadow.exists(w) ? shadow[w] : {w, w};
  endfunction

  function automatic wordT mergeBytes(input wordT old, input wordT data, input maskT mask);
    wordT r;
    r = old;
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) begin
        r[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return r;
  endfunction

  task automatic checkVal(input string name, input logic [63:0] got, input logic [63:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("error: time %0t, %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // memory side, all handshakes driven on the falling edge
  always @(negedge clk) begin
    rdReqReady_i  = 1'b0;
    rdBeatValid_i = 1'b0;
    rdLast_i      = 1'b0;
    wbReady_i     = 1'b0;
    if (rst_n) begin
      if (rdActive) begin
        if (!bpOn || randBits(1) != 0) begin
          rdBeatValid_i = 1'b1;
          rdBeat_i      = memRead(rdAddr + addrT'(8 * beatIdx));
          rdLast_i      = (beatIdx == BeatsPerLine - 1);
          beatIdx++;
          if (beatIdx == BeatsPerLine) begin
            rdActive = 1'b0;
          end
        end
      end else if (rdReqValid_o && (!bpOn || randBits(1) != 0)) begin
        rdReqReady_i = 1'b1;
        rdAddr       = rdReqAddr_o;
        lastRdAddr   = rdReqAddr_o;
        rdActive     = 1'b1;
        beatIdx      = 0;
        rdCount++;
      end
      if (wbValid_o && (!bpOn || randBits(1) != 0)) begin
        wbReady_i  = 1'b1;
        lastWbAddr = wb_o.addr;
        wbCount++;
        // a dirty line carries what the pipeline last stored
        for (int i = 0; i < BeatsPerLine; i++) begin
          checkVal("wb_o.data", wb_o.data[i*64 +: 64], expectRead(wb_o.addr + addrT'(8 * i)));
          memModel[wb_o.addr + addrT'(8 * i)] = wb_o.data[i*64 +: 64];
        end
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TimeoutCycles) begin
      $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("errors: %0d, checks: %0d", errCount, checkCount);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // one request, returns the load data and the cycles from acceptance to dataOk_o
  task automatic doReq(input logic isStore, input addrT addr, input wordT data,
                       input maskT mask, output wordT rdData, output int cycles);
    @(negedge clk);
    while (!reqReady_o) begin
      @(negedge clk);
    end
    reqValid_i     = 1'b1;
    req_i.isStore  = isStore;
    req_i.addr     = addr;
    req_i.wrData   = data;
    req_i.wrMask   = mask;
    @(negedge clk);
    reqValid_i = 1'b0;
    cycles     = 1;
    while (!dataOk_o) begin
      @(negedge clk);
      cycles++;
    end
    rdData = rdData_o;
  endtask

  task automatic loadCheck(input addrT a, input bit expHit, input string what);
    wordT d;
    int   cyc;
    int   rdBefore;
    rdBefore = rdCount;
    doReq(1'b0, a, '0, '0, d, cyc);
    checkVal({what, " rdData_o"}, d, expectRead(a));
    checkVal({what, " hit"}, cyc == 1, expHit);
    checkVal({what, " read requests"}, rdCount - rdBefore, expHit ? 0 : 1);
  endtask

  task automatic storeWord(input addrT a, input bit expHit, input string what);
    wordT d;
    maskT m;
    wordT unused;
    int   cyc;
    d = {randBits(32), randBits(32)};
    m = maskT'(randBits(8));
    doReq(1'b1, a, d, m, unused, cyc);
    checkVal({what, " hit"}, cyc == 1, expHit);
    shadow[{a[31:3], 3'b000}] = mergeBytes(expectRead(a), d, m);
  endtask

  task automatic resetTest();
    repeat (3) begin
      @(negedge clk);
      checkVal("reqReady_o", reqReady_o, 1);
      checkVal("rdReqValid_o", rdReqValid_o, 0);
      checkVal("wbValid_o", wbValid_o, 0);
      checkVal("dataOk_o", dataOk_o, 0);
    end
  endtask

  task automatic missHitTest(input int idx);
    addrT a;
    int   wbBefore;
    a        = mkAddr(5, idx, 2);
    wbBefore = wbCount;
    loadCheck(a, 1'b0, "first load");
    checkVal("rdReqAddr_o", lastRdAddr, lineOf(a));
    loadCheck(a, 1'b1, "repeat load");
    checkVal("write-back count", wbCount - wbBefore, 0);
  endtask

  task automatic storeMergeTest(input int idx);
    addrT a;
    addrT b;
    a = mkAddr(7, idx, 1);
    b = mkAddr(9, idx, 3);
    loadCheck(a, 1'b0, "load before store");
    storeWord(a, 1'b1, "store on hit");
    loadCheck(a, 1'b1, "load after store hit");
    storeWord(b, 1'b0, "store on miss");
    loadCheck(b, 1'b1, "load after store miss");
  endtask

  // consecutive misses alternate ways, so the third tag evicts the first
  task automatic conflictTest(input int idx);
    addrT a;
    addrT b;
    addrT c;
    int   wbBefore;
    a        = mkAddr(11, idx, 0);
    b        = mkAddr(12, idx, 1);
    c        = mkAddr(13, idx, 3);
    wbBefore = wbCount;
    loadCheck(a, 1'b0, "load tag A");
    loadCheck(b, 1'b0, "load tag B");
    loadCheck(c, 1'b0, "load tag C");
    loadCheck(b, 1'b1, "tag B kept");
    loadCheck(a, 1'b0, "evicted tag A");
    loadCheck(c, 1'b1, "tag C kept");
    loadCheck(b, 1'b0, "evicted tag B");
    checkVal("write-back count", wbCount - wbBefore, 0);
  endtask

  task automatic dirtyTest(input int idx);
    addrT a;
    addrT b;
    addrT c;
    int   wbBefore;
    a = mkAddr(21, idx, 2);
    b = mkAddr(22, idx, 0);
    c = mkAddr(23, idx, 1);
    storeWord(a, 1'b0, "store to tag A");
    wbBefore = wbCount;
    loadCheck(b, 1'b0, "load tag B");
    checkVal("write-back count", wbCount - wbBefore, 0);
    loadCheck(c, 1'b0, "load tag C");
    checkVal("write-back count", wbCount - wbBefore, 1);
    checkVal("wb_o.addr", lastWbAddr, lineOf(a));
    loadCheck(a, 1'b0, "reload tag A");
    checkVal("rdReqAddr_o", lastRdAddr, lineOf(a));
    checkVal("write-back count", wbCount - wbBefore, 1);
  endtask

  initial begin
    lfsrState  = 32'haff3_d42b;
    rst_n      = 1'b0;
    reqValid_i = 1'b0;
    req_i      = '0;
    bpOn       = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    resetTest();
    missHitTest(1);
    storeMergeTest(2);
    conflictTest(3);
    dirtyTest(4);
    // same tests with random ready and beat gaps
    bpOn = 1'b1;
    for (int k = 0; k < 4; k++) begin
      missHitTest(10 + k * 4);
      storeMergeTest(11 + k * 4);
      conflictTest(12 + k * 4);
      dirtyTest(13 + k * 4);
    end
    $display("errors: %0d, checks: %0d", errCount, checkCount);
    if (errCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- list.f
dcachePkg.sv
dcacheCtrl.sv
tagStore.sv
dataStore.sv
refillBuffer.sv
dcacheTop.sv
dcache_assert.sv
dcacheTb.sv

//--- run.sh
#!/bin/sh
# build and run the cache testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dcacheTb -f list.f \
  && ./obj_dir/VdcacheTb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^STATUS: PASS$" sim.log && echo "simulation passed" && exit 0
echo "simulation failed" || true
exit 1
